/* tb.f */
exu_pkg.sv
alu_eu.sv
operand_select_eu.sv
cdb_arbiter.sv
exec_stage.sv
exec_stage_properties.sv
tb_exec_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the execution-stage testbench with Verilator and runs it.
# Exits non-zero unless the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_exec_stage -o sim_exec_stage
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out="$(./obj_dir/sim_exec_stage 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" <<< "$sim_out"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_exec_stage.sv */
/*
 * Testbench for the execution stage.
 * Plays dispatch with random issue from a fixed seed, predicts every
 * result with a reference model and matches each CDB transfer against
 * one queue per unit. Run through run.sh with the tb.f file list.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_stage;

    import exu_pkg::*;

    localparam int N_ALU   = 200;
    localparam int N_SEL   = 200;
    localparam int N_MIX   = 300;
    // Issues on each side of the flush
    localparam int N_FLUSH = 100;
    localparam int TIMEOUT_CYCLES = (N_ALU + N_SEL + N_MIX + 2 * N_FLUSH) * 8 + 200;

    typedef struct packed {
        logic [TAG_LEN-1:0]    tag;
        logic [XLEN-1:0]       value;
        logic                  except;
        logic [EXCEPT_LEN-1:0] code;
    } exp_t;

    logic                  clk_i = 1'b0;
    logic                  cdb_ready_i = 1'b1;
    logic                  rst_n_i, flush_i, issue_valid_i, issue_ready_o;
    eu_sel_e               issue_eu_i;
    logic [CTL_LEN-1:0]    issue_ctl_i;
    logic [XLEN-1:0]       issue_rs1_i, issue_rs2_i;
    logic [TAG_LEN-1:0]    issue_tag_i;
    logic                  cdb_valid_o, cdb_except_o;
    logic [TAG_LEN-1:0]    cdb_tag_o;
    logic [XLEN-1:0]       cdb_value_o;
    logic [EXCEPT_LEN-1:0] cdb_except_code_o;

    // Pending results per unit in issue order
    exp_t alu_q[$];
    exp_t sel_q[$];
    // A tag is free when it has come back as often as it was handed out
    int alloc_cnt[2**TAG_LEN];
    int done_cnt[2**TAG_LEN];
    logic [TAG_LEN-1:0] tag_ptr;
    logic bp_on, flush_hold;
    int errors, checks, issued, tests, cycle_cnt;
    // Owned by the CDB monitor
    // received counts every CDB transfer, expected or not
    int mon_errors, mon_checks, received;
    int unsigned seed_val;

    exec_stage dut0 (.*);

    always #20 clk_i = ~clk_i;

    // Random CDB back-pressure when enabled
    // Held low around a flush
    always @(posedge clk_i) begin
        #1;
        if (flush_hold) begin
            cdb_ready_i = 1'b0;
        end else if (bp_on) begin
            cdb_ready_i = ($urandom % 3) != 0;
        end else begin
            cdb_ready_i = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with results still missing", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    // Inputs are stable at the falling edge
    // A transfer seen here completes on the next rising edge
    always @(negedge clk_i) begin : cdb_monitor
        exp_t e;
        logic hit;
        if (rst_n_i && !flush_i && cdb_valid_o && cdb_ready_i) begin
            hit = 1'b0;
            e   = '0;
            if (alu_q.size() > 0 && alu_q[0].tag == cdb_tag_o) begin
                e   = alu_q.pop_front();
                hit = 1'b1;
            end else if (sel_q.size() > 0 && sel_q[0].tag == cdb_tag_o) begin
                e   = sel_q.pop_front();
                hit = 1'b1;
            end
            mon_checks++;
            received++;
            assert (hit) else begin
                $display("Unexpected CDB result at %0t ns with tag %0d", $time, cdb_tag_o);
                mon_errors++;
            end
            if (hit) begin
                mon_checks++;
                assert (cdb_value_o == e.value && cdb_except_o == e.except &&
                        cdb_except_code_o == e.code) else begin
                    $display("** Error at %0t ns: tag %0d got %h exc %b/%0d, want %h exc %b/%0d",
                             $time, cdb_tag_o, cdb_value_o, cdb_except_o, cdb_except_code_o,
                             e.value, e.except, e.code);
                    mon_errors++;
                end
                done_cnt[cdb_tag_o]++;
            end
        end
    end

    // Reference model
    function automatic exp_t model_result(input eu_sel_e eu, input logic [CTL_LEN-1:0] ctl,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        exp_t   e;
        longint wide;
        e = '0;
        if (eu == EU_SEL) begin
            // Code 0 picks rs2 and code 2 gives zero
            // All other codes pick rs1
            e.value = (ctl == 4'd0) ? b : (ctl == 4'd2) ? XLEN'(0) : a;
        end else begin
            case (ctl)
                ADD:  e.value = a + b;
                SUB:  e.value = a - b;
                AND:  e.value = a & b;
                OR:   e.value = a | b;
                XOR:  e.value = a ^ b;
                SLL:  e.value = a << b[4:0];
                SRL:  e.value = a >> b[4:0];
                SLT:  e.value = ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
                ADDV: begin
                    e.value = a + b;
                    wide    = longint'($signed(a)) + longint'($signed(b));
                    if (wide > 64'sd2147483647 || wide < -64'sd2147483648) begin
                        e.except = 1'b1;
                        e.code   = EXC_OVERFLOW;
                    end
                end
                default: begin
                    e.except = 1'b1;
                    e.code   = EXC_ILLEGAL;
                end
            endcase
        end
        return e;
    endfunction

    task automatic take_free_tag(output logic [TAG_LEN-1:0] tag);
        logic [TAG_LEN-1:0] cand;
        logic               found;
        found = 1'b0;
        tag   = tag_ptr;
        while (!found) begin
            for (int i = 0; i < 2**TAG_LEN; i++) begin
                cand = tag_ptr + TAG_LEN'(i);
                if (!found && alloc_cnt[cand] == done_cnt[cand]) begin
                    tag   = cand;
                    found = 1'b1;
                end
            end
            if (!found) begin
                @(posedge clk_i);
                #1;
            end
        end
        alloc_cnt[tag]++;
        tag_ptr = tag + 1'b1;
    endtask

    // Called 1 ns after a rising edge and returns the same way
    task automatic issue_op(input eu_sel_e eu, input logic [CTL_LEN-1:0] ctl,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [TAG_LEN-1:0] tag;
        exp_t               e;
        take_free_tag(tag);
        e     = model_result(eu, ctl, a, b);
        e.tag = tag;
        issue_valid_i = 1'b1;
        issue_eu_i    = eu;
        issue_ctl_i   = ctl;
        issue_rs1_i   = a;
        issue_rs2_i   = b;
        issue_tag_i   = tag;
        @(negedge clk_i);
        while (!issue_ready_o) begin
            @(negedge clk_i);
        end
        if (eu == EU_ALU) begin
            alu_q.push_back(e);
        end else begin
            sel_q.push_back(e);
        end
        issued++;
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
    endtask

    task automatic random_issue(input eu_sel_e eu);
        logic [CTL_LEN-1:0] ctl;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        a   = $urandom;
        b   = $urandom;
        ctl = CTL_LEN'($urandom % 16);
        if (eu == EU_ALU && ctl == ADDV && $urandom % 2 == 0) begin
            // Two large operands of one sign always wrap
            a = {2'b01, a[XLEN-3:0]};
            b = {2'b01, b[XLEN-3:0]};
            if ($urandom % 2 == 1) begin
                a = ~a;
                b = ~b;
            end
        end
        issue_op(eu, ctl, a, b);
    endtask

    task automatic random_mix(input int n);
        repeat (n) begin
            random_issue(($urandom % 2 == 1) ? EU_SEL : EU_ALU);
            if ($urandom % 4 == 0) begin
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    task automatic drain();
        while (alu_q.size() > 0 || sel_q.size() > 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // One flush cycle with a dropped issue while the CDB is stalled
    task automatic apply_flush();
        @(negedge clk_i);
        flush_hold = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i       = 1'b1;
        issue_valid_i = 1'b1;
        issue_eu_i    = ($urandom % 2 == 1) ? EU_SEL : EU_ALU;
        issue_ctl_i   = CTL_LEN'($urandom % 16);
        issue_rs1_i   = $urandom;
        issue_tag_i   = tag_ptr - 1'b1;
        @(posedge clk_i);
        #1;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        alu_q.delete();
        sel_q.delete();
        foreach (alloc_cnt[t]) begin
            alloc_cnt[t] = done_cnt[t];
        end
        @(negedge clk_i);
        flush_hold = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    task automatic end_test(input string name, input int err_mark);
        tests++;
        if (errors + mon_errors == err_mark) begin
            $display("test %0d %s ok", tests, name);
        end else begin
            $display("test %0d %s FAILED with %0d errors", tests, name,
                     errors + mon_errors - err_mark);
        end
    endtask

    initial begin
        int err_mark;
        int recv_mark;
        int issue_mark;
        seed_val      = $urandom(23);
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_eu_i    = EU_ALU;
        issue_ctl_i   = '0;
        issue_rs1_i   = '0;
        issue_rs2_i   = '0;
        issue_tag_i   = '0;
        bp_on         = 1'b0;
        flush_hold    = 1'b0;
        tag_ptr       = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Reset state seen from both issue targets
        err_mark = errors + mon_errors;
        @(negedge clk_i);
        checks++;
        assert (!cdb_valid_o && issue_ready_o) else begin
            $display("** Error at %0t ns: after reset cdb_valid %b, ALU ready %b",
                     $time, cdb_valid_o, issue_ready_o);
            errors++;
        end
        @(posedge clk_i);
        #1;
        issue_eu_i = EU_SEL;
        @(negedge clk_i);
        checks++;
        assert (issue_ready_o) else begin
            $display("** Error at %0t ns: select unit not ready after reset", $time);
            errors++;
        end
        @(posedge clk_i);
        #1;
        end_test("reset state", err_mark);

        err_mark = errors + mon_errors;
        repeat (N_ALU) random_issue(EU_ALU);
        drain();
        end_test("ALU results", err_mark);

        err_mark = errors + mon_errors;
        repeat (N_SEL) random_issue(EU_SEL);
        drain();
        end_test("operand select", err_mark);

        // Both units under random back-pressure
        err_mark   = errors + mon_errors;
        issue_mark = issued;
        recv_mark  = received;
        bp_on      = 1'b1;
        random_mix(N_MIX);
        drain();
        checks++;
        assert (received - recv_mark == issued - issue_mark) else begin
            $display("Mixed test issued %0d results but the CDB carried %0d",
                     issued - issue_mark, received - recv_mark);
            errors++;
        end
        end_test("mixed contention", err_mark);

        err_mark = errors + mon_errors;
        random_mix(N_FLUSH);
        apply_flush();
        recv_mark = received;
        random_mix(N_FLUSH);
        drain();
        checks++;
        assert (received - recv_mark == N_FLUSH) else begin
            $display("After the flush %0d results arrived instead of %0d",
                     received - recv_mark, N_FLUSH);
            errors++;
        end
        end_test("flush", err_mark);

        $display("%0d tests, %0d checks, %0d errors, %0d issued, %0d received", tests,
                 checks + mon_checks, errors + mon_errors, issued, received);
        if (errors + mon_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_stage_properties.sv */
/*
 * Concurrent checks on the execution stage result bus and reset state.
 * Bound into exec_stage, so every instance carries them.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_stage_properties (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           flush_i,
    input logic                           issue_ready_o,
    input logic                           cdb_valid_o,
    input logic                           cdb_ready_i,
    input logic [exu_pkg::TAG_LEN-1:0]    cdb_tag_o,
    input logic [exu_pkg::XLEN-1:0]       cdb_value_o,
    input logic                           cdb_except_o,
    input logic [exu_pkg::EXCEPT_LEN-1:0] cdb_except_code_o
);

    // Stalled CDB keeps valid and payload
    cdb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o && !cdb_ready_i && !flush_i |=> cdb_valid_o && $stable(cdb_tag_o) &&
        $stable(cdb_value_o) && $stable(cdb_except_o) && $stable(cdb_except_code_o))
        else $error("CDB result changed or dropped while stalled");

    // Empty bus right after reset release
    reset_empty_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !cdb_valid_o)
        else $error("CDB valid in the first cycle after reset");

    flush_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !cdb_valid_o)
        else $error("CDB valid in the cycle after a flush");

    reset_ready_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> issue_ready_o)
        else $error("Issue not ready in the first cycle after reset");

endmodule

bind exec_stage exec_stage_properties props0 (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .issue_ready_o(issue_ready_o),
    .cdb_valid_o(cdb_valid_o),
    .cdb_ready_i(cdb_ready_i),
    .cdb_tag_o(cdb_tag_o),
    .cdb_value_o(cdb_value_o),
    .cdb_except_o(cdb_except_o),
    .cdb_except_code_o(cdb_except_code_o)
);

`default_nettype wire

/* exec_stage.sv */
/*
 * Execution stage top level.
 * Steers each issued instruction to the ALU or the operand-select
 * unit and merges both result streams onto the CDB through the arbiter.
 */

`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    // Issue from dispatch
    input  logic                           issue_valid_i,
    output logic                           issue_ready_o,
    input  exu_pkg::eu_sel_e               issue_eu_i,
    input  logic [exu_pkg::CTL_LEN-1:0]    issue_ctl_i,
    input  logic [exu_pkg::XLEN-1:0]       issue_rs1_i,
    input  logic [exu_pkg::XLEN-1:0]       issue_rs2_i,
    input  logic [exu_pkg::TAG_LEN-1:0]    issue_tag_i,
    // Result bus
    output logic                           cdb_valid_o,
    input  logic                           cdb_ready_i,
    output logic [exu_pkg::TAG_LEN-1:0]    cdb_tag_o,
    output logic [exu_pkg::XLEN-1:0]       cdb_value_o,
    output logic                           cdb_except_o,
    output logic [exu_pkg::EXCEPT_LEN-1:0] cdb_except_code_o
);

    import exu_pkg::*;

    // Per-unit issue handshake
    logic alu_valid, alu_ready;
    logic sel_valid, sel_ready;

    // Unit results toward the arbiter
    logic                  alu_res_valid, alu_res_ready, alu_res_except;
    logic [TAG_LEN-1:0]    alu_res_tag;
    logic [XLEN-1:0]       alu_res_value;
    logic [EXCEPT_LEN-1:0] alu_res_code;
    logic                  sel_res_valid, sel_res_ready, sel_res_except;
    logic [TAG_LEN-1:0]    sel_res_tag;
    logic [XLEN-1:0]       sel_res_value;
    logic [EXCEPT_LEN-1:0] sel_res_code;

    // Issue steering
    assign alu_valid     = issue_valid_i && (issue_eu_i == EU_ALU);
    assign sel_valid     = issue_valid_i && (issue_eu_i == EU_SEL);
    assign issue_ready_o = (issue_eu_i == EU_SEL) ? sel_ready : alu_ready;

    alu_eu alu_eu0 (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i(alu_valid), .ready_o(alu_ready), .ctl_i(issue_ctl_i),
        .rs1_i(issue_rs1_i), .rs2_i(issue_rs2_i), .tag_i(issue_tag_i),
        .res_valid_o(alu_res_valid), .res_ready_i(alu_res_ready),
        .res_tag_o(alu_res_tag), .res_value_o(alu_res_value),
        .res_except_o(alu_res_except), .res_except_code_o(alu_res_code)
    );

    operand_select_eu sel_eu0 (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i(sel_valid), .ready_o(sel_ready), .ctl_i(issue_ctl_i),
        .rs1_i(issue_rs1_i), .rs2_i(issue_rs2_i), .tag_i(issue_tag_i),
        .res_valid_o(sel_res_valid), .res_ready_i(sel_res_ready),
        .res_tag_o(sel_res_tag), .res_value_o(sel_res_value),
        .res_except_o(sel_res_except), .res_except_code_o(sel_res_code)
    );

    cdb_arbiter arb0 (
        .clk_i, .rst_n_i, .flush_i,
        .alu_valid_i(alu_res_valid), .alu_ready_o(alu_res_ready),
        .alu_tag_i(alu_res_tag), .alu_value_i(alu_res_value),
        .alu_except_i(alu_res_except), .alu_except_code_i(alu_res_code),
        .sel_valid_i(sel_res_valid), .sel_ready_o(sel_res_ready),
        .sel_tag_i(sel_res_tag), .sel_value_i(sel_res_value),
        .sel_except_i(sel_res_except), .sel_except_code_i(sel_res_code),
        .cdb_valid_o, .cdb_ready_i, .cdb_tag_o, .cdb_value_o,
        .cdb_except_o, .cdb_except_code_o
    );

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
/*
 * Common-data-bus arbiter.
 * Picks one of the two unit results with round-robin priority and
 * loads it into a one-entry CDB register. The register refills only
 * when empty or drained by cdb_ready_i in the same cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    // ALU unit result
    input  logic                           alu_valid_i,
    output logic                           alu_ready_o,
    input  logic [exu_pkg::TAG_LEN-1:0]    alu_tag_i,
    input  logic [exu_pkg::XLEN-1:0]       alu_value_i,
    input  logic                           alu_except_i,
    input  logic [exu_pkg::EXCEPT_LEN-1:0] alu_except_code_i,
    // Operand-select unit result
    input  logic                           sel_valid_i,
    output logic                           sel_ready_o,
    input  logic [exu_pkg::TAG_LEN-1:0]    sel_tag_i,
    input  logic [exu_pkg::XLEN-1:0]       sel_value_i,
    input  logic                           sel_except_i,
    input  logic [exu_pkg::EXCEPT_LEN-1:0] sel_except_code_i,
    // Result bus
    output logic                           cdb_valid_o,
    input  logic                           cdb_ready_i,
    output logic [exu_pkg::TAG_LEN-1:0]    cdb_tag_o,
    output logic [exu_pkg::XLEN-1:0]       cdb_value_o,
    output logic                           cdb_except_o,
    output logic [exu_pkg::EXCEPT_LEN-1:0] cdb_except_code_o
);

    // Set when the select unit won the last grant
    logic last_sel;
    logic can_load;
    logic load;

    // Nothing moves while a flush is in progress
    assign can_load = (!cdb_valid_o || cdb_ready_i) && !flush_i;

    // Round-robin: on contention the unit not granted last wins
    assign alu_ready_o = can_load && alu_valid_i && (!sel_valid_i || last_sel);
    assign sel_ready_o = can_load && sel_valid_i && (!alu_valid_i || !last_sel);
    assign load        = alu_ready_o || sel_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
            // ALU gets the first grant
            last_sel    <= 1'b1;
        end else if (flush_i) begin
            cdb_valid_o <= 1'b0;
        end else if (load) begin
            cdb_valid_o <= 1'b1;
            last_sel    <= sel_ready_o;
        end else if (cdb_ready_i) begin
            cdb_valid_o <= 1'b0;
        end
    end

    // CDB payload from the granted unit
    always_ff @(posedge clk_i) begin
        if (alu_ready_o) begin
            cdb_tag_o         <= alu_tag_i;
            cdb_value_o       <= alu_value_i;
            cdb_except_o      <= alu_except_i;
            cdb_except_code_o <= alu_except_code_i;
        end else if (sel_ready_o) begin
            cdb_tag_o         <= sel_tag_i;
            cdb_value_o       <= sel_value_i;
            cdb_except_o      <= sel_except_i;
            cdb_except_code_o <= sel_except_code_i;
        end
    end

endmodule

`default_nettype wire

/* operand_select_eu.sv */
/*
 * Two-stage operand-select execution unit.
 * Stage 1 latches the issued control, operands and tag, stage 2 holds
 * rs1, rs2 or zero for the CDB arbiter. Two instructions can be
 * in flight. This unit never raises an exception.
 */

`timescale 1ns/1ns
`default_nettype none

module operand_select_eu (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    // Issue side
    input  logic                           valid_i,
    output logic                           ready_o,
    input  logic [exu_pkg::CTL_LEN-1:0]    ctl_i,
    input  logic [exu_pkg::XLEN-1:0]       rs1_i,
    input  logic [exu_pkg::XLEN-1:0]       rs2_i,
    input  logic [exu_pkg::TAG_LEN-1:0]    tag_i,
    // Result side
    output logic                           res_valid_o,
    input  logic                           res_ready_i,
    output logic [exu_pkg::TAG_LEN-1:0]    res_tag_o,
    output logic [exu_pkg::XLEN-1:0]       res_value_o,
    output logic                           res_except_o,
    output logic [exu_pkg::EXCEPT_LEN-1:0] res_except_code_o
);

    import exu_pkg::*;

    // Stage 1 registers
    logic               s1_valid;
    logic [CTL_LEN-1:0] s1_ctl;
    logic [XLEN-1:0]    s1_rs1;
    logic [XLEN-1:0]    s1_rs2;
    logic [TAG_LEN-1:0] s1_tag;

    logic            s2_free;
    logic            s1_advance;
    logic            accept;
    logic [XLEN-1:0] sel_value;

    assign s2_free    = !res_valid_o || res_ready_i;
    assign s1_advance = s1_valid && s2_free;
    assign ready_o    = !s1_valid || s2_free;
    assign accept     = valid_i && ready_o && !flush_i;

    // Operand choice, unknown codes fall back to rs1
    always_comb begin
        case (sel_op_e'(s1_ctl))
            SEL_RS2:  sel_value = s1_rs2;
            SEL_ZERO: sel_value = '0;
            default:  sel_value = s1_rs1;
        endcase
    end

    // Stage valids
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid    <= 1'b0;
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            s1_valid    <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_advance) begin
                s1_valid <= 1'b0;
            end
            if (s1_advance) begin
                res_valid_o <= 1'b1;
            end else if (res_ready_i) begin
                res_valid_o <= 1'b0;
            end
        end
    end

    // Stage payloads
    always_ff @(posedge clk_i) begin
        if (accept) begin
            s1_ctl <= ctl_i;
            s1_rs1 <= rs1_i;
            s1_rs2 <= rs2_i;
            s1_tag <= tag_i;
        end
        if (s1_advance) begin
            res_tag_o   <= s1_tag;
            res_value_o <= sel_value;
        end
    end

    assign res_except_o      = 1'b0;
    assign res_except_code_o = EXC_NONE;

endmodule

`default_nettype wire

/* alu_eu.sv */
/*
 * Integer ALU execution unit.
 * Computes the result in the issue cycle and keeps it in a single
 * output slot until the CDB arbiter takes it. Accepts a new
 * instruction in the same cycle the held result leaves.
 */

`timescale 1ns/1ns
`default_nettype none

module alu_eu (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    // Issue side
    input  logic                           valid_i,
    output logic                           ready_o,
    input  logic [exu_pkg::CTL_LEN-1:0]    ctl_i,
    input  logic [exu_pkg::XLEN-1:0]       rs1_i,
    input  logic [exu_pkg::XLEN-1:0]       rs2_i,
    input  logic [exu_pkg::TAG_LEN-1:0]    tag_i,
    // Result side
    output logic                           res_valid_o,
    input  logic                           res_ready_i,
    output logic [exu_pkg::TAG_LEN-1:0]    res_tag_o,
    output logic [exu_pkg::XLEN-1:0]       res_value_o,
    output logic                           res_except_o,
    output logic [exu_pkg::EXCEPT_LEN-1:0] res_except_code_o
);

    import exu_pkg::*;

    alu_op_e         op;
    logic [XLEN-1:0] sum;
    logic            add_ovf;
    logic [XLEN-1:0] alu_value;
    exc_code_e       alu_exc;
    logic            accept;

    assign op  = alu_op_e'(ctl_i);
    assign sum = rs1_i + rs2_i;
    // Signed overflow: same operand signs, different result sign
    assign add_ovf = (rs1_i[XLEN-1] == rs2_i[XLEN-1]) && (sum[XLEN-1] != rs1_i[XLEN-1]);

    // Result and exception decode
    always_comb begin
        alu_value = '0;
        alu_exc   = EXC_NONE;
        case (op)
            ADD:  alu_value = sum;
            SUB:  alu_value = rs1_i - rs2_i;
            AND:  alu_value = rs1_i & rs2_i;
            OR:   alu_value = rs1_i | rs2_i;
            XOR:  alu_value = rs1_i ^ rs2_i;
            SLL:  alu_value = rs1_i << rs2_i[SHAMT_LEN-1:0];
            SRL:  alu_value = rs1_i >> rs2_i[SHAMT_LEN-1:0];
            SLT:  alu_value = {{(XLEN-1){1'b0}}, $signed(rs1_i) < $signed(rs2_i)};
            ADDV: begin
                // Wrapped sum is still returned with the trap
                alu_value = sum;
                if (add_ovf) begin
                    alu_exc = EXC_OVERFLOW;
                end
            end
            default: begin
                alu_value = '0;
                alu_exc   = EXC_ILLEGAL;
            end
        endcase
    end

    // Slot is free or being emptied this cycle
    assign ready_o = !res_valid_o || res_ready_i;
    // Issue during flush is dropped
    assign accept  = valid_i && ready_o && !flush_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0;
        end else if (accept) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_tag_o         <= tag_i;
            res_value_o       <= alu_value;
            res_except_o      <= (alu_exc != EXC_NONE);
            res_except_code_o <= alu_exc;
        end
    end

endmodule

`default_nettype wire

/* exu_pkg.sv */
/*
 * Shared widths and encodings for the execution stage.
 * Every unit, the CDB arbiter and the top level take their sizes
 * and opcode encodings from here.
 */

`default_nettype none

package exu_pkg;

    // Operand and result width
    localparam int XLEN       = 32;
    // Shift amount width, low bits of rs2
    localparam int SHAMT_LEN  = $clog2(XLEN);
    // Reservation-station entry index
    localparam int TAG_LEN    = 3;
    // Control field from dispatch
    localparam int CTL_LEN    = 4;
    // Exception code width
    localparam int EXCEPT_LEN = 2;

    // ALU operations, any code above ADDV is illegal
    typedef enum logic [CTL_LEN-1:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SLT  = 4'd7,
        ADDV = 4'd8
    } alu_op_e;

    // Operand-select controls
    // Codes not listed here pick rs1
    typedef enum logic [CTL_LEN-1:0] {
        SEL_RS2  = 4'd0,
        SEL_RS1  = 4'd1,
        SEL_ZERO = 4'd2
    } sel_op_e;

    // Exception codes reported with a result
    typedef enum logic [EXCEPT_LEN-1:0] {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1,
        EXC_ILLEGAL  = 2'd2
    } exc_code_e;

    // Target unit of an issued instruction
    typedef enum logic {
        EU_ALU = 1'b0,
        EU_SEL = 1'b1
    } eu_sel_e;

endpackage

`default_nettype wire
